// ==== hw/link_pkg.sv ====
package link_pkg;

    // Packet type field.
    localparam int BT_W = 4;
    typedef logic [BT_W-1:0] btype_t;

    localparam btype_t BT_NONE   = 4'd0;
    localparam btype_t BT_ACK    = 4'd1;
    localparam btype_t BT_NAK    = 4'd2;
    localparam btype_t BT_RLY    = 4'd3;
    localparam btype_t BT_DIDX   = 4'd5;
    localparam btype_t BT_DPARAM = 4'd6;
    localparam btype_t BT_DDIDX  = 4'd7;
    localparam btype_t BT_LINK   = 4'd9;
    // Marks a corrupted frame and is never sent on the link.
    localparam btype_t BT_ERROR  = 4'd15;

    // Payload length field is split over header bytes 1 and 2.
    localparam int LEN_W = 12;

    // Upper nibble of the first frame byte.
    localparam logic [3:0] FRAME_MARK = 4'd5;

    // Types that the peer may send as commands.
    function automatic logic is_command(input btype_t t);
        return (t == BT_DIDX) || (t == BT_DPARAM) || (t == BT_DDIDX) || (t == BT_LINK);
    endfunction

endpackage

// ==== hw/payload_ram.sv ====
`timescale 1ns/1ns

module payload_ram #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [7:0]        wdata,
    input  logic [ADDR_W-1:0] raddr,
    output logic [7:0]        rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [7:0] mem [0:DEPTH-1];

    // Host write port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read with one cycle latency.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hw/frame_tx.sv ====
`timescale 1ns/1ns

module frame_tx #(
    parameter int ADDR_W = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    output logic                       done,
    input  link_pkg::btype_t           btype,
    input  logic [ADDR_W-1:0]          addr,
    input  logic [link_pkg::LEN_W-1:0] len,
    output logic [ADDR_W-1:0]          ram_raddr,
    input  logic [7:0]                 ram_rdata,
    output logic [7:0]                 tx_data,
    output logic                       tx_valid,
    input  logic                       tx_ready
);

    // State names the byte currently held on tx_data.
    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_LENH,
        S_LENL,
        S_DATA,
        S_SUM,
        S_DONE
    } state_t;

    state_t                     state;
    logic [ADDR_W-1:0]          rd_ptr;
    logic [link_pkg::LEN_W-1:0] cnt;
    logic [7:0]                 csum;
    logic [7:0]                 next_byte;
    logic                       accept;
    logic                       load;
    logic                       load_data;

    assign accept    = tx_valid && tx_ready;
    assign load      = (state == S_IDLE) ? start
                     : (accept && (state != S_SUM) && (state != S_DONE));
    assign load_data = accept && ((state == S_LENL) || (state == S_DATA)) && (cnt != '0);
    assign done      = (state == S_DONE);

    // Read one byte ahead so payload bytes follow without gaps.
    assign ram_raddr = load_data ? rd_ptr + 1'b1 : rd_ptr;

    always_comb begin
        case (state)
            S_IDLE:  next_byte = {link_pkg::FRAME_MARK, btype};
            S_HDR:   next_byte = {4'h0, cnt[link_pkg::LEN_W-1:8]};
            S_LENH:  next_byte = cnt[7:0];
            default: next_byte = (cnt != '0) ? ram_rdata : csum;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            tx_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_HDR;
                        tx_valid <= 1'b1;
                    end
                end
                S_HDR: begin
                    if (accept) state <= S_LENH;
                end
                S_LENH: begin
                    if (accept) state <= S_LENL;
                end
                S_LENL, S_DATA: begin
                    if (accept) state <= (cnt == '0) ? S_SUM : S_DATA;
                end
                S_SUM: begin
                    if (accept) begin
                        state    <= S_DONE;
                        tx_valid <= 1'b0;
                    end
                end
                S_DONE: begin
                    if (!start) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_data <= next_byte;
            csum    <= (state == S_IDLE) ? next_byte : csum ^ next_byte;
        end
        if (state == S_IDLE) begin
            rd_ptr <= addr;
            cnt    <= len;
        end else if (load_data) begin
            rd_ptr <= rd_ptr + 1'b1;
            cnt    <= cnt - 1'b1;
        end
    end

endmodule

// ==== hw/frame_rx.sv ====
`timescale 1ns/1ns

module frame_rx (
    input  logic             clk,
    input  logic             rst,
    input  logic [7:0]       rx_data,
    input  logic             rx_valid,
    output logic             rx_ready,
    output logic             frame,
    output link_pkg::btype_t btype,
    input  logic             taken
);

    typedef enum logic [2:0] {
        R_HUNT,
        R_LENH,
        R_LENL,
        R_DATA,
        R_SUM,
        R_HOLD
    } state_t;

    state_t                     state;
    link_pkg::btype_t           hdr_type;
    logic [link_pkg::LEN_W-1:0] cnt;
    logic [7:0]                 csum;
    logic                       accept;

    // Back-pressure while a frame waits for the session.
    assign rx_ready = (state != R_HOLD);
    assign frame    = (state == R_HOLD);
    assign accept   = rx_valid && rx_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= R_HUNT;
            btype <= link_pkg::BT_NONE;
        end else begin
            case (state)
                R_HUNT: begin
                    // Bytes without the mark are dropped.
                    if (accept && (rx_data[7:4] == link_pkg::FRAME_MARK)) begin
                        state <= R_LENH;
                    end
                end
                R_LENH: begin
                    if (accept) state <= R_LENL;
                end
                R_LENL: begin
                    if (accept) begin
                        state <= ({cnt[link_pkg::LEN_W-1:8], rx_data} == '0) ? R_SUM : R_DATA;
                    end
                end
                R_DATA: begin
                    if (accept && (cnt == 1)) state <= R_SUM;
                end
                R_SUM: begin
                    if (accept) begin
                        state <= R_HOLD;
                        btype <= (rx_data == csum) ? hdr_type : link_pkg::BT_ERROR;
                    end
                end
                R_HOLD: begin
                    if (taken) state <= R_HUNT;
                end
                default: state <= R_HUNT;
            endcase
        end
    end

    // Payload bytes only feed the checksum and the length count.
    always_ff @(posedge clk) begin
        if (accept) begin
            csum <= (state == R_HUNT) ? rx_data : csum ^ rx_data;
            case (state)
                R_HUNT:  hdr_type <= rx_data[3:0];
                R_LENH:  cnt[link_pkg::LEN_W-1:8] <= rx_data[3:0];
                R_LENL:  cnt[7:0] <= rx_data;
                R_DATA:  cnt <= cnt - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/link_session.sv ====
`timescale 1ns/1ns

module link_session #(
    parameter int ADDR_W      = 8,
    parameter int ANS_TIMEOUT = 64,
    parameter int RETRY_MAX   = 10
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       send_start,
    output logic                       send_done,
    output logic                       send_fail,
    input  link_pkg::btype_t           send_btype,
    input  logic [link_pkg::LEN_W-1:0] send_len,
    input  logic [ADDR_W-1:0]          send_addr,

    output logic                       read_valid,
    output link_pkg::btype_t           read_btype,
    input  logic                       read_ack,

    output logic                       tx_start,
    input  logic                       tx_done,
    output link_pkg::btype_t           tx_btype,
    output logic [ADDR_W-1:0]          tx_addr,
    output logic [link_pkg::LEN_W-1:0] tx_len,

    input  logic                       rx_frame,
    input  link_pkg::btype_t           rx_btype,
    output logic                       rx_taken
);

    localparam int TW = $clog2(ANS_TIMEOUT + 1);
    localparam int NW = $clog2(RETRY_MAX + 1);
    localparam logic [TW-1:0] T_LAST = TW'(ANS_TIMEOUT - 1);
    localparam logic [NW-1:0] N_MAX  = NW'(RETRY_MAX);

    typedef enum logic [3:0] {
        S_IDLE,
        S_SEND_TX,
        S_ANS_WAIT,
        S_ANS_TAKE,
        S_SEND_OK,
        S_SEND_FAIL,
        S_RX_TAKE,
        S_REP_TX,
        S_RLY_WAIT,
        S_RLY_TAKE,
        S_READ
    } state_t;

    state_t          state;
    state_t          next_state;
    logic [TW-1:0]   time_cnt;
    logic [NW-1:0]   num_cnt;
    logic            tout;
    logic            last_try;
    logic            rx_end;

    assign tout     = (time_cnt == T_LAST);
    assign last_try = (num_cnt >= N_MAX);
    // frame_rx has released the frame and still holds its type.
    assign rx_end   = !rx_frame;

    assign send_done  = (state == S_SEND_OK) || (state == S_SEND_FAIL);
    assign send_fail  = (state == S_SEND_FAIL);
    assign read_valid = (state == S_READ);
    assign tx_start   = (state == S_SEND_TX) || (state == S_REP_TX);
    assign rx_taken   = (state == S_ANS_TAKE) || (state == S_RX_TAKE) || (state == S_RLY_TAKE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (send_start) next_state = S_SEND_TX;
                else if (rx_frame) next_state = S_RX_TAKE;
            end
            S_SEND_TX: begin
                if (tx_done) next_state = S_ANS_WAIT;
            end
            S_ANS_WAIT: begin
                if (rx_frame) next_state = S_ANS_TAKE;
                else if (tout) next_state = last_try ? S_SEND_FAIL : S_SEND_TX;
            end
            S_ANS_TAKE: begin
                // Anything but NAK counts as accepted.
                if (rx_end) begin
                    if (rx_btype != link_pkg::BT_NAK) next_state = S_SEND_OK;
                    else next_state = last_try ? S_SEND_FAIL : S_SEND_TX;
                end
            end
            S_SEND_OK, S_SEND_FAIL: begin
                if (!send_start) next_state = S_IDLE;
            end
            S_RX_TAKE: begin
                if (rx_end) begin
                    if ((rx_btype == link_pkg::BT_ERROR) || link_pkg::is_command(rx_btype)) begin
                        next_state = S_REP_TX;
                    end else begin
                        next_state = S_IDLE;
                    end
                end
            end
            S_REP_TX: begin
                // No RLY is expected after a NAK.
                if (tx_done) begin
                    next_state = (tx_btype == link_pkg::BT_NAK) ? S_IDLE : S_RLY_WAIT;
                end
            end
            S_RLY_WAIT: begin
                if (rx_frame) next_state = S_RLY_TAKE;
                else if (tout) next_state = last_try ? S_IDLE : S_REP_TX;
            end
            S_RLY_TAKE: begin
                if (rx_end) begin
                    if (rx_btype == link_pkg::BT_RLY) next_state = S_READ;
                    else next_state = last_try ? S_IDLE : S_REP_TX;
                end
            end
            S_READ: begin
                if (read_ack || tout) next_state = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
    end

    // Runs only in the waiting states.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            time_cnt <= '0;
        end else if ((state == S_ANS_WAIT) || (state == S_RLY_WAIT) || (state == S_READ)) begin
            time_cnt <= time_cnt + 1'b1;
        end else begin
            time_cnt <= '0;
        end
    end

    // Transmissions or replies in the current exchange.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num_cnt <= '0;
        end else if (state == S_IDLE) begin
            num_cnt <= '0;
        end else if (tx_start && tx_done) begin
            num_cnt <= num_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_btype <= link_pkg::BT_NONE;
            tx_addr  <= '0;
            tx_len   <= '0;
        end else if ((state == S_IDLE) && send_start) begin
            tx_btype <= send_btype;
            tx_addr  <= send_addr;
            tx_len   <= send_len;
        end else if ((state == S_RX_TAKE) && rx_end) begin
            // Replies carry no payload.
            tx_btype <= (rx_btype == link_pkg::BT_ERROR) ? link_pkg::BT_NAK : link_pkg::BT_ACK;
            tx_len   <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_btype <= link_pkg::BT_NONE;
        end else if ((state == S_RX_TAKE) && rx_end && link_pkg::is_command(rx_btype)) begin
            read_btype <= rx_btype;
        end
    end

endmodule

// ==== hw/link_top.sv ====
`timescale 1ns/1ns

module link_top #(
    parameter int ADDR_W      = 8,
    parameter int ANS_TIMEOUT = 64,
    parameter int RETRY_MAX   = 10
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       send_start,
    input  link_pkg::btype_t           send_btype,
    input  logic [link_pkg::LEN_W-1:0] send_len,
    input  logic [ADDR_W-1:0]          send_addr,
    output logic                       send_done,
    output logic                       send_fail,

    output logic                       read_valid,
    output link_pkg::btype_t           read_btype,
    input  logic                       read_ack,

    input  logic                       ram_we,
    input  logic [ADDR_W-1:0]          ram_waddr,
    input  logic [7:0]                 ram_wdata,

    output logic [7:0]                 tx_data,
    output logic                       tx_valid,
    input  logic                       tx_ready,

    input  logic [7:0]                 rx_data,
    input  logic                       rx_valid,
    output logic                       rx_ready
);

    logic                       tx_start;
    logic                       tx_done;
    link_pkg::btype_t           tx_btype;
    logic [ADDR_W-1:0]          tx_addr;
    logic [link_pkg::LEN_W-1:0] tx_len;
    logic [ADDR_W-1:0]          ram_raddr;
    logic [7:0]                 ram_rdata;
    logic                       rx_frame;
    link_pkg::btype_t           rx_btype;
    logic                       rx_taken;

    payload_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    frame_tx #(
        .ADDR_W (ADDR_W)
    ) u_frame_tx (
        .clk       (clk),
        .rst       (rst),
        .start     (tx_start),
        .done      (tx_done),
        .btype     (tx_btype),
        .addr      (tx_addr),
        .len       (tx_len),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

    frame_rx u_frame_rx (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .frame    (rx_frame),
        .btype    (rx_btype),
        .taken    (rx_taken)
    );

    link_session #(
        .ADDR_W      (ADDR_W),
        .ANS_TIMEOUT (ANS_TIMEOUT),
        .RETRY_MAX   (RETRY_MAX)
    ) u_session (
        .clk        (clk),
        .rst        (rst),
        .send_start (send_start),
        .send_done  (send_done),
        .send_fail  (send_fail),
        .send_btype (send_btype),
        .send_len   (send_len),
        .send_addr  (send_addr),
        .read_valid (read_valid),
        .read_btype (read_btype),
        .read_ack   (read_ack),
        .tx_start   (tx_start),
        .tx_done    (tx_done),
        .tx_btype   (tx_btype),
        .tx_addr    (tx_addr),
        .tx_len     (tx_len),
        .rx_frame   (rx_frame),
        .rx_btype   (rx_btype),
        .rx_taken   (rx_taken)
    );

endmodule

// ==== sim/link_chk.sv ====
`timescale 1ns/1ns

module link_chk (
    input logic       clk,
    input logic       rst,
    input logic [7:0] tx_data,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic       send_done,
    input logic       send_fail,
    input logic       read_valid
);

    int hold_fails = 0;
    int fail_fails = 0;
    int read_fails = 0;

    // Offered byte waits unchanged for tx_ready.
    a_tx_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
    ) else begin
        hold_fails++;
        $error("tx byte withdrawn or changed before it was accepted");
    end

    a_fail_done: assert property (
        @(posedge clk) disable iff (rst)
        send_fail |-> send_done
    ) else begin
        fail_fails++;
        $error("send_fail high without send_done");
    end

    // No command is presented while a send result is shown.
    a_read_idle: assert property (
        @(posedge clk) disable iff (rst)
        send_done |-> !read_valid
    ) else begin
        read_fails++;
        $error("read_valid high while send_done is high");
    end

endmodule

bind link_top link_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .send_done  (send_done),
    .send_fail  (send_fail),
    .read_valid (read_valid)
);

// ==== sim/link_tb.sv ====
`timescale 1ns/1ns

module link_tb;

    localparam int ADDR_W      = 8;
    localparam int ANS_TIMEOUT = 64;
    localparam int RETRY_MAX   = 3;
    localparam int WAIT_LIMIT  = 2000;

    typedef logic [7:0] bytes_t[$];

    logic                       clk;
    logic                       rst;
    logic                       send_start;
    link_pkg::btype_t           send_btype;
    logic [link_pkg::LEN_W-1:0] send_len;
    logic [ADDR_W-1:0]          send_addr;
    logic                       send_done;
    logic                       send_fail;
    logic                       read_valid;
    link_pkg::btype_t           read_btype;
    logic                       read_ack;
    logic                       ram_we;
    logic [ADDR_W-1:0]          ram_waddr;
    logic [7:0]                 ram_wdata;
    logic [7:0]                 tx_data;
    logic                       tx_valid;
    logic                       tx_ready;
    logic [7:0]                 rx_data;
    logic                       rx_valid;
    logic                       rx_ready;

    integer seed = 32'hd9b7;
    int     errors = 0;
    int     tests = 0;
    int     tests_failed = 0;
    int     tx_count = 0;
    int     assert_fails;
    bytes_t exp_q;
    bytes_t none;

    link_top #(
        .ADDR_W      (ADDR_W),
        .ANS_TIMEOUT (ANS_TIMEOUT),
        .RETRY_MAX   (RETRY_MAX)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .send_start (send_start),
        .send_btype (send_btype),
        .send_len   (send_len),
        .send_addr  (send_addr),
        .send_done  (send_done),
        .send_fail  (send_fail),
        .read_valid (read_valid),
        .read_btype (read_btype),
        .read_ack   (read_ack),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Peer accepts about three bytes in four.
    always @(posedge clk) begin
        #1;
        tx_ready = ($random(seed) & 3) != 0;
    end

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_btype(input link_pkg::btype_t got, input link_pkg::btype_t exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("timeout at %0t ns: %s", $time, what);
    endtask

    // Every accepted byte is compared with the next expected one.
    always @(negedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected byte %h sent on the link at %0t ns", tx_data, $time);
            end else begin
                check_byte(tx_data, exp_q.pop_front(), "tx byte");
            end
            tx_count++;
        end
    end

    // Header, length, payload, then the XOR of everything before.
    function automatic bytes_t build_frame(input link_pkg::btype_t t, input bytes_t pay);
        bytes_t      frm;
        logic [11:0] len;
        logic [7:0]  sum;
        len = 12'(pay.size());
        frm.push_back({link_pkg::FRAME_MARK, t});
        frm.push_back({4'h0, len[11:8]});
        frm.push_back(len[7:0]);
        foreach (pay[i]) frm.push_back(pay[i]);
        sum = 8'h00;
        foreach (frm[i]) sum = sum ^ frm[i];
        frm.push_back(sum);
        return frm;
    endfunction

    function automatic bytes_t make_payload(input int n);
        bytes_t pay;
        for (int i = 0; i < n; i++) begin
            pay.push_back(8'($random(seed)));
        end
        return pay;
    endfunction

    task automatic expect_frame(input bytes_t frm);
        foreach (frm[i]) exp_q.push_back(frm[i]);
    endtask

    task automatic finish_test(input string name, input int base);
        tests++;
        if (errors == base) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests, name, errors - base);
        end
    endtask

    task automatic load_payload(input logic [ADDR_W-1:0] addr, input bytes_t pay);
        foreach (pay[i]) begin
            ram_we    = 1'b1;
            ram_waddr = addr + ADDR_W'(i);
            ram_wdata = pay[i];
            @(posedge clk);
            #1;
        end
        ram_we = 1'b0;
    endtask

    task automatic send_frame(input bytes_t frm);
        int t;
        foreach (frm[i]) begin
            rx_data  = frm[i];
            rx_valid = 1'b1;
            t = 0;
            while (!rx_ready && t < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                t++;
            end
            if (!rx_ready) note_timeout("peer byte never accepted by rx_ready");
            @(posedge clk);
            #1;
        end
        rx_valid = 1'b0;
    endtask

    task automatic wait_tx_bytes(input int target);
        int t;
        t = 0;
        while (tx_count < target && t < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (tx_count < target) note_timeout("transmitted frame did not complete");
    endtask

    task automatic wait_send_done(input logic level);
        int t;
        t = 0;
        while (send_done !== level && t < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (send_done !== level) note_timeout("send_done did not change as expected");
    endtask

    task automatic wait_read_valid(input logic level);
        int t;
        t = 0;
        while (read_valid !== level && t < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (read_valid !== level) note_timeout("read_valid did not change as expected");
    endtask

    task automatic start_send(input link_pkg::btype_t t, input int len,
                              input logic [ADDR_W-1:0] addr);
        send_btype = t;
        send_len   = len[link_pkg::LEN_W-1:0];
        send_addr  = addr;
        send_start = 1'b1;
    endtask

    task automatic end_send();
        send_start = 1'b0;
        wait_send_done(1'b0);
    endtask

    // Command, ACK reply, RLY, then the host read.
    task automatic command_exchange(input link_pkg::btype_t cmd, input bytes_t pay);
        int mark;
        mark = tx_count;
        expect_frame(build_frame(link_pkg::BT_ACK, none));
        send_frame(build_frame(cmd, pay));
        wait_tx_bytes(mark + 4);
        send_frame(build_frame(link_pkg::BT_RLY, none));
        wait_read_valid(1'b1);
        check_btype(read_btype, cmd, "read_btype");
        read_ack = 1'b1;
        @(posedge clk);
        #1;
        read_ack = 1'b0;
        check_flag(read_valid, 1'b0, "read_valid after read_ack");
    endtask

    initial begin
        bytes_t pay1;
        bytes_t pay2;
        bytes_t bad;
        bytes_t junk;
        int     base;
        int     mark;
        logic   seen;
        rst        = 1'b1;
        send_start = 1'b0;
        send_btype = link_pkg::BT_NONE;
        send_len   = '0;
        send_addr  = '0;
        read_ack   = 1'b0;
        ram_we     = 1'b0;
        ram_waddr  = '0;
        ram_wdata  = 8'h00;
        tx_ready   = 1'b0;
        rx_data    = 8'h00;
        rx_valid   = 1'b0;
        pay1 = make_payload(20);
        pay2 = make_payload(5);
        junk = '{8'h00, 8'ha3, 8'h17, 8'hff, 8'h4e};
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Payload crosses the top of the buffer.
        base = errors;
        load_payload(8'hf8, pay1);
        mark = tx_count;
        expect_frame(build_frame(link_pkg::BT_DIDX, pay1));
        start_send(link_pkg::BT_DIDX, pay1.size(), 8'hf8);
        wait_tx_bytes(mark + pay1.size() + 4);
        send_frame(build_frame(link_pkg::BT_ACK, none));
        wait_send_done(1'b1);
        check_flag(send_fail, 1'b0, "send_fail");
        end_send();
        finish_test("send with ack", base);

        base = errors;
        load_payload(8'h10, pay2);
        mark = tx_count;
        expect_frame(build_frame(link_pkg::BT_DDIDX, pay2));
        start_send(link_pkg::BT_DDIDX, pay2.size(), 8'h10);
        for (int k = 0; k < 2; k++) begin
            wait_tx_bytes(mark + (k + 1) * (pay2.size() + 4));
            expect_frame(build_frame(link_pkg::BT_DDIDX, pay2));
            send_frame(build_frame(link_pkg::BT_NAK, none));
        end
        wait_tx_bytes(mark + 3 * (pay2.size() + 4));
        send_frame(build_frame(link_pkg::BT_ACK, none));
        wait_send_done(1'b1);
        check_flag(send_fail, 1'b0, "send_fail");
        end_send();
        finish_test("nak retry", base);

        // Silent peer.
        base = errors;
        mark = tx_count;
        for (int k = 0; k < RETRY_MAX; k++) begin
            expect_frame(build_frame(link_pkg::BT_LINK, pay2));
        end
        start_send(link_pkg::BT_LINK, pay2.size(), 8'h10);
        wait_tx_bytes(mark + RETRY_MAX * (pay2.size() + 4));
        wait_send_done(1'b1);
        check_flag(send_fail, 1'b1, "send_fail");
        check_flag(tx_count == mark + RETRY_MAX * (pay2.size() + 4), 1'b1, "frame count");
        end_send();
        finish_test("retry exhaustion", base);

        base = errors;
        command_exchange(link_pkg::BT_DPARAM, pay2);
        finish_test("command reception", base);

        base = errors;
        mark = tx_count;
        bad = build_frame(link_pkg::BT_LINK, pay2);
        bad[bad.size() - 1] = bad[bad.size() - 1] ^ 8'h01;
        expect_frame(build_frame(link_pkg::BT_NAK, none));
        send_frame(bad);
        wait_tx_bytes(mark + 4);
        seen = 1'b0;
        repeat (4 * ANS_TIMEOUT) begin
            @(posedge clk);
            #1;
            seen = seen | read_valid;
        end
        check_flag(seen, 1'b0, "read_valid after a corrupted command");
        finish_test("corrupted command", base);

        base = errors;
        send_frame(junk);
        command_exchange(link_pkg::BT_DPARAM, none);
        finish_test("resynchronization", base);

        assert_fails = dut.u_chk.hold_fails + dut.u_chk.fail_fails + dut.u_chk.read_fails;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/link_pkg.sv
hw/payload_ram.sv
hw/frame_tx.sv
hw/frame_rx.sv
hw/link_session.sv
hw/link_top.sv
sim/link_chk.sv
sim/link_tb.sv
